// ==== aluControl.sv ====
`default_nettype none

module aluControl (
    input  mipsExPkg::decodedT stage,
    output mipsExPkg::aluCtrlE ctrl,
    output logic               useShamt,
    output logic               hiLoUpdate,
    output logic               illegal
);

    always_comb begin
        ctrl       = mipsExPkg::aluAdd;
        useShamt   = 1'b0;
        hiLoUpdate = 1'b0;
        illegal    = 1'b0;
        case (stage.aluOp)
            mipsExPkg::rType: begin
                case (stage.funct)
                    mipsExPkg::fnAdd,
                    mipsExPkg::fnAddu: ctrl = mipsExPkg::aluAdd; // no overflow trap
                    mipsExPkg::fnSub:  ctrl = mipsExPkg::aluSub;
                    mipsExPkg::fnAnd:  ctrl = mipsExPkg::aluAnd;
                    mipsExPkg::fnOr:   ctrl = mipsExPkg::aluOr;
                    mipsExPkg::fnXor:  ctrl = mipsExPkg::aluXor;
                    mipsExPkg::fnNor:  ctrl = mipsExPkg::aluNor;
                    mipsExPkg::fnSlt:  ctrl = mipsExPkg::aluSlt;
                    mipsExPkg::fnSltu: ctrl = mipsExPkg::aluSltu;
                    mipsExPkg::fnMovn: ctrl = mipsExPkg::aluMovn;
                    mipsExPkg::fnMovz: ctrl = mipsExPkg::aluMovz;
                    mipsExPkg::fnMfhi: ctrl = mipsExPkg::aluMfhi;
                    mipsExPkg::fnMflo: ctrl = mipsExPkg::aluMflo;
                    mipsExPkg::fnSll: begin
                        ctrl     = mipsExPkg::aluSll;
                        useShamt = 1'b1;
                    end
                    mipsExPkg::fnSrl: begin
                        ctrl     = stage.rBit21 ? mipsExPkg::aluRotr : mipsExPkg::aluSrl;
                        useShamt = 1'b1;
                    end
                    mipsExPkg::fnSra: begin
                        ctrl     = mipsExPkg::aluSra;
                        useShamt = 1'b1;
                    end
                    mipsExPkg::fnSllv: ctrl = mipsExPkg::aluSll; // amount from rs
                    mipsExPkg::fnSrlv: begin
                        ctrl = stage.rBit6 ? mipsExPkg::aluRotr : mipsExPkg::aluSrl;
                    end
                    mipsExPkg::fnSrav: ctrl = mipsExPkg::aluSra;
                    mipsExPkg::fnMult: begin
                        ctrl       = mipsExPkg::aluMult;
                        hiLoUpdate = 1'b1;
                    end
                    mipsExPkg::fnMultu: begin
                        ctrl       = mipsExPkg::aluMultu;
                        hiLoUpdate = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            mipsExPkg::special2: begin
                case (stage.funct)
                    mipsExPkg::fnMul: ctrl = mipsExPkg::aluMul; // leaves hi/lo alone
                    mipsExPkg::fnMadd: begin
                        ctrl       = mipsExPkg::aluMadd;
                        hiLoUpdate = 1'b1;
                    end
                    mipsExPkg::fnMsub: begin
                        ctrl       = mipsExPkg::aluMsub;
                        hiLoUpdate = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            mipsExPkg::addImm: ctrl = mipsExPkg::aluAdd;
            mipsExPkg::andImm: ctrl = mipsExPkg::aluAnd;
            mipsExPkg::orImm:  ctrl = mipsExPkg::aluOr;
            mipsExPkg::xorImm: ctrl = mipsExPkg::aluXor;
            mipsExPkg::sltImm: ctrl = mipsExPkg::aluSlt;
            default:           illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== aluCore.sv ====
`default_nettype none

module aluCore (
    input  mipsExPkg::decodedT stage,
    input  mipsExPkg::aluCtrlE ctrl,
    input  logic               useShamt,
    input  mipsExPkg::wordT    hi,
    input  mipsExPkg::wordT    lo,
    output mipsExPkg::wordT    result
);

    mipsExPkg::wordT  opA;
    mipsExPkg::wordT  opB;
    mipsExPkg::shamtT sa;
    mipsExPkg::wordT  prodLo;
    logic [63:0]      rotPair;

    assign opA = stage.rs;
    assign opB = (stage.aluOp == mipsExPkg::rType || stage.aluOp == mipsExPkg::special2) ?
                 stage.rt : stage.imm;
    assign sa  = useShamt ? stage.shamt : stage.rs[4:0];

    // low half of the product is the same for signed and unsigned
    assign prodLo  = stage.rs * stage.rt;
    assign rotPair = {stage.rt, stage.rt} >> sa;

    always_comb begin
        case (ctrl)
            mipsExPkg::aluAdd:   result = opA + opB;
            mipsExPkg::aluSub:   result = opA - opB;
            mipsExPkg::aluAnd:   result = opA & opB;
            mipsExPkg::aluOr:    result = opA | opB;
            mipsExPkg::aluXor:   result = opA ^ opB;
            mipsExPkg::aluNor:   result = ~(opA | opB);
            mipsExPkg::aluSll:   result = stage.rt << sa;
            mipsExPkg::aluSrl:   result = stage.rt >> sa;
            mipsExPkg::aluSra:   result = $signed(stage.rt) >>> sa;
            mipsExPkg::aluRotr:  result = rotPair[31:0];
            mipsExPkg::aluSlt:   result = {31'b0, $signed(opA) < $signed(opB)};
            mipsExPkg::aluSltu:  result = {31'b0, opA < opB};
            mipsExPkg::aluMovn:  result = (stage.rt != '0) ? stage.rs : stage.rt;
            mipsExPkg::aluMovz:  result = (stage.rt == '0) ? stage.rs : stage.rt;
            mipsExPkg::aluMul,
            mipsExPkg::aluMult,
            mipsExPkg::aluMultu: result = prodLo;
            // carries only move upward, so the new lo needs no hi
            mipsExPkg::aluMadd:  result = lo + prodLo;
            mipsExPkg::aluMsub:  result = lo - prodLo;
            mipsExPkg::aluMfhi:  result = hi;
            mipsExPkg::aluMflo:  result = lo;
            default:             result = opA + opB;
        endcase
    end

endmodule

`default_nettype wire

// ==== exInput.sv ====
`default_nettype none

module exInput (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    output logic                inReady,
    input  mipsExPkg::exReqT    inReq,
    input  logic                advance,
    output logic                stageValid,
    output mipsExPkg::decodedT  stage
);

    mipsExPkg::opcodeT  opcode;
    mipsExPkg::decodedT stageD;
    mipsExPkg::decodedT payloadQ;
    mipsExPkg::aluOpE   aluOpQ;
    logic               accept;

    assign opcode  = inReq.instr[31:26];
    assign inReady = !stageValid || advance;
    assign accept  = inValid && inReady;

    always_comb begin
        stageD.funct  = inReq.instr[5:0];
        stageD.shamt  = inReq.instr[10:6];
        stageD.rs     = inReq.rs;
        stageD.rt     = inReq.rt;
        stageD.rBit6  = inReq.instr[6];
        stageD.rBit21 = inReq.instr[21];
        stageD.imm    = {{16{inReq.instr[15]}}, inReq.instr[15:0]};
        case (opcode)
            mipsExPkg::opSpecial:  stageD.aluOp = mipsExPkg::rType;
            mipsExPkg::opSpecial2: stageD.aluOp = mipsExPkg::special2;
            mipsExPkg::opAddi,
            mipsExPkg::opAddiu:    stageD.aluOp = mipsExPkg::addImm;
            mipsExPkg::opSlti:     stageD.aluOp = mipsExPkg::sltImm;
            mipsExPkg::opAndi:     stageD.aluOp = mipsExPkg::andImm;
            mipsExPkg::opOri:      stageD.aluOp = mipsExPkg::orImm;
            mipsExPkg::opXori:     stageD.aluOp = mipsExPkg::xorImm;
            default:               stageD.aluOp = mipsExPkg::rType; // decoded by funct
        endcase
        // logical immediates are zero extended
        if (opcode == mipsExPkg::opAndi || opcode == mipsExPkg::opOri ||
            opcode == mipsExPkg::opXori) begin
            stageD.imm = {16'b0, inReq.instr[15:0]};
        end
    end

    // op class drops to a plain add while the stage is empty
    always_ff @(posedge clk) begin
        if (!rstN) begin
            stageValid <= 1'b0;
            aluOpQ     <= mipsExPkg::addImm;
        end else if (accept) begin
            stageValid <= 1'b1;
            aluOpQ     <= stageD.aluOp;
        end else if (advance) begin
            stageValid <= 1'b0;
            aluOpQ     <= mipsExPkg::addImm;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            payloadQ <= stageD;
        end
    end

    always_comb begin
        stage       = payloadQ;
        stage.aluOp = aluOpQ;
    end

    assert property (@(posedge clk) disable iff (!rstN)
        inValid && !inReady |=> inValid && $stable(inReq))
        else $error("request changed while stalled");

endmodule

`default_nettype wire

// ==== exOutput.sv ====
`default_nettype none

module exOutput (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stageValid,
    input  mipsExPkg::exRespT resp,
    output logic              canAccept,
    output logic              outValid,
    input  logic              outReady,
    output mipsExPkg::exRespT outResp
);

    assign canAccept = !outValid || outReady; // empty or draining

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (canAccept) begin
            outValid <= stageValid;
        end
    end

    always_ff @(posedge clk) begin
        if (canAccept && stageValid) begin
            outResp <= resp;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outResp))
        else $error("response dropped or changed under back-pressure");

endmodule

`default_nettype wire

// ==== hiLoUnit.sv ====
`default_nettype none

module hiLoUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               advance,
    input  logic               stageValid,
    input  logic               hiLoUpdate,
    input  mipsExPkg::aluCtrlE ctrl,
    input  mipsExPkg::wordT    rs,
    input  mipsExPkg::wordT    rt,
    output mipsExPkg::wordT    hi,
    output mipsExPkg::wordT    lo,
    output mipsExPkg::wordT    nextHi,
    output mipsExPkg::wordT    nextLo
);

    logic signed [63:0] prodS;
    logic [63:0]        prodU;
    logic [63:0]        hiLo;
    logic [63:0]        hiLoNext;

    assign prodS = $signed(rs) * $signed(rt);
    assign prodU = {32'b0, rs} * {32'b0, rt};
    assign hiLo  = {hi, lo};

    always_comb begin
        hiLoNext = hiLo;
        if (hiLoUpdate) begin
            case (ctrl)
                mipsExPkg::aluMult:  hiLoNext = prodS;
                mipsExPkg::aluMultu: hiLoNext = prodU;
                mipsExPkg::aluMadd:  hiLoNext = hiLo + prodS;
                mipsExPkg::aluMsub:  hiLoNext = hiLo - prodS;
                default:             hiLoNext = hiLo;
            endcase
        end
    end

    assign nextHi = hiLoNext[63:32];
    assign nextLo = hiLoNext[31:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (advance && hiLoUpdate) begin // commit only when leaving stage one
            hi <= nextHi;
            lo <= nextLo;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        hiLoUpdate |-> stageValid)
        else $error("hi/lo write from an empty stage");

endmodule

`default_nettype wire

// ==== mipsExPkg.sv ====
`default_nettype none

package mipsExPkg;

    typedef logic [31:0] wordT;
    typedef logic [31:0] instrT;
    typedef logic [5:0] functT;
    typedef logic [5:0] opcodeT;
    typedef logic [4:0] shamtT;

    // primary opcodes
    localparam opcodeT opSpecial  = 6'b000000;
    localparam opcodeT opSpecial2 = 6'b011100;
    localparam opcodeT opAddi     = 6'b001000;
    localparam opcodeT opAddiu    = 6'b001001;
    localparam opcodeT opAndi     = 6'b001100;
    localparam opcodeT opOri      = 6'b001101;
    localparam opcodeT opXori     = 6'b001110;
    localparam opcodeT opSlti     = 6'b001010;

    // SPECIAL functs
    localparam functT fnSll   = 6'b000000;
    localparam functT fnSrl   = 6'b000010; // rotr when bit 21 set
    localparam functT fnSra   = 6'b000011;
    localparam functT fnSllv  = 6'b000100;
    localparam functT fnSrlv  = 6'b000110; // rotrv when bit 6 set
    localparam functT fnSrav  = 6'b000111;
    localparam functT fnMovz  = 6'b001010;
    localparam functT fnMovn  = 6'b001011;
    localparam functT fnMfhi  = 6'b010000;
    localparam functT fnMflo  = 6'b010010;
    localparam functT fnMult  = 6'b011000;
    localparam functT fnMultu = 6'b011001;
    localparam functT fnAdd   = 6'b100000;
    localparam functT fnAddu  = 6'b100001;
    localparam functT fnSub   = 6'b100010;
    localparam functT fnAnd   = 6'b100100;
    localparam functT fnOr    = 6'b100101;
    localparam functT fnXor   = 6'b100110;
    localparam functT fnNor   = 6'b100111;
    localparam functT fnSlt   = 6'b101010;
    localparam functT fnSltu  = 6'b101011;

    // SPECIAL2 functs
    localparam functT fnMadd = 6'b000000;
    localparam functT fnMul  = 6'b000010;
    localparam functT fnMsub = 6'b000100;

    typedef enum logic [2:0] {
        rType, addImm, special2, andImm, orImm, xorImm, sltImm
    } aluOpE;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSll, aluSrl, aluSra, aluRotr, aluSlt, aluSltu,
        aluMovn, aluMovz, aluMul, aluMult, aluMultu,
        aluMadd, aluMsub, aluMfhi, aluMflo
    } aluCtrlE;

    typedef struct packed {
        instrT instr;
        wordT  rs;
        wordT  rt;
    } exReqT;

    typedef struct packed {
        aluOpE aluOp;
        functT funct;
        shamtT shamt;
        wordT  imm;     // already extended
        wordT  rs;
        wordT  rt;
        logic  rBit6;
        logic  rBit21;
    } decodedT;

    typedef struct packed {
        wordT result;
        wordT hi;
        wordT lo;
    } exRespT;

endpackage

`default_nettype wire

// ==== mipsExTop.sv ====
`default_nettype none

module mipsExTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    output logic              inReady,
    input  mipsExPkg::exReqT  inReq,
    output logic              outValid,
    input  logic              outReady,
    output mipsExPkg::exRespT outResp,
    output logic              illegal
);

    mipsExPkg::decodedT stage;
    mipsExPkg::aluCtrlE ctrl;
    mipsExPkg::wordT    aluResult;
    mipsExPkg::wordT    hi;
    mipsExPkg::wordT    lo;
    mipsExPkg::wordT    nextHi;
    mipsExPkg::wordT    nextLo;
    mipsExPkg::exRespT  resp;
    logic               stageValid;
    logic               useShamt;
    logic               hiLoUpdate;
    logic               canAccept;
    logic               advance;

    assign advance = stageValid && canAccept;
    assign resp    = '{result: aluResult, hi: nextHi, lo: nextLo}; // post-update hi/lo

    exInput i_exInput (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .inReq(inReq),
        .advance(advance), .stageValid(stageValid), .stage(stage)
    );

    aluControl i_aluControl (
        .stage(stage), .ctrl(ctrl), .useShamt(useShamt), .hiLoUpdate(hiLoUpdate),
        .illegal(illegal)
    );

    aluCore i_aluCore (
        .stage(stage), .ctrl(ctrl), .useShamt(useShamt), .hi(hi), .lo(lo),
        .result(aluResult)
    );

    hiLoUnit i_hiLoUnit (
        .clk(clk), .rstN(rstN), .advance(advance), .stageValid(stageValid),
        .hiLoUpdate(hiLoUpdate), .ctrl(ctrl), .rs(stage.rs), .rt(stage.rt),
        .hi(hi), .lo(lo), .nextHi(nextHi), .nextLo(nextLo)
    );

    exOutput i_exOutput (
        .clk(clk), .rstN(rstN), .stageValid(stageValid), .resp(resp),
        .canAccept(canAccept), .outValid(outValid), .outReady(outReady), .outResp(outResp)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module tbMipsEx -o simMipsEx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/simMipsEx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== tbMipsExVectors.svh ====
localparam int numVec = 36;

// name, instr, rs, rt, result, hi, lo
vecT vectors [numVec] = '{
    '{"mfhiRst ", 32'h00003010, 32'h00000000, 32'h00000000, 32'h00000000, 32'h0, 32'h0},
    '{"addu    ", 32'h00853021, 32'h00001234, 32'hfffffff0, 32'h00001224, 32'h0, 32'h0},
    '{"add     ", 32'h00853020, 32'h7fffffff, 32'h00000001, 32'h80000000, 32'h0, 32'h0},
    '{"sub     ", 32'h00853022, 32'h00000005, 32'h00000007, 32'hfffffffe, 32'h0, 32'h0},
    '{"and     ", 32'h00853024, 32'hf0f01234, 32'h0ff0ff00, 32'h00f01200, 32'h0, 32'h0},
    '{"or      ", 32'h00853025, 32'hf0f01234, 32'h0ff0ff00, 32'hfff0ff34, 32'h0, 32'h0},
    '{"xor     ", 32'h00853026, 32'hf0f01234, 32'h0ff0ff00, 32'hff00ed34, 32'h0, 32'h0},
    '{"nor     ", 32'h00853027, 32'hf0f01234, 32'h0ff0ff00, 32'h000f00cb, 32'h0, 32'h0},
    '{"slt     ", 32'h0085302a, 32'hffffffff, 32'h00000001, 32'h00000001, 32'h0, 32'h0},
    '{"sltu    ", 32'h0085302b, 32'hffffffff, 32'h00000001, 32'h00000000, 32'h0, 32'h0},
    '{"addi    ", 32'h2085fffe, 32'h0000000a, 32'h00000000, 32'h00000008, 32'h0, 32'h0},
    '{"addiu   ", 32'h24858000, 32'h00010000, 32'h00000000, 32'h00008000, 32'h0, 32'h0},
    '{"andi    ", 32'h3085ff0f, 32'hffffffff, 32'h00000000, 32'h0000ff0f, 32'h0, 32'h0},
    '{"ori     ", 32'h34858001, 32'h12340000, 32'h00000000, 32'h12348001, 32'h0, 32'h0},
    '{"xori    ", 32'h3885ffff, 32'haaaa5555, 32'h00000000, 32'haaaaaaaa, 32'h0, 32'h0},
    '{"slti    ", 32'h2885ffff, 32'h00000005, 32'h00000000, 32'h00000000, 32'h0, 32'h0},
    '{"sll     ", 32'h00053100, 32'h00000000, 32'h8000000f, 32'h000000f0, 32'h0, 32'h0},
    '{"srl     ", 32'h00053202, 32'h00000000, 32'h80001234, 32'h00800012, 32'h0, 32'h0},
    '{"sra     ", 32'h00053203, 32'h00000000, 32'h80001234, 32'hff800012, 32'h0, 32'h0},
    '{"rotr    ", 32'h00253202, 32'h00000000, 32'h80001234, 32'h34800012, 32'h0, 32'h0},
    '{"sllv    ", 32'h00853004, 32'h00000024, 32'h0000000f, 32'h000000f0, 32'h0, 32'h0},
    '{"srlv    ", 32'h00853006, 32'h00000004, 32'h1234567f, 32'h01234567, 32'h0, 32'h0},
    '{"srav    ", 32'h00853007, 32'h00000004, 32'hf0000000, 32'hff000000, 32'h0, 32'h0},
    '{"rotrv   ", 32'h00853046, 32'h00000004, 32'h1234567f, 32'hf1234567, 32'h0, 32'h0},
    '{"movn    ", 32'h0085300b, 32'h11111111, 32'h00000002, 32'h11111111, 32'h0, 32'h0},
    '{"movnF   ", 32'h0085300b, 32'h44444444, 32'h00000000, 32'h00000000, 32'h0, 32'h0},
    '{"movz    ", 32'h0085300a, 32'h22222222, 32'h00000000, 32'h22222222, 32'h0, 32'h0},
    '{"movzF   ", 32'h0085300a, 32'h22222222, 32'h33333333, 32'h33333333, 32'h0, 32'h0},
    // running hi:lo from here on
    '{"mult    ", 32'h00850018, 32'hfffffffe, 32'h00000003, 32'hfffffffa,
      32'hffffffff, 32'hfffffffa},
    '{"mfhi    ", 32'h00003010, 32'h00000000, 32'h00000000, 32'hffffffff,
      32'hffffffff, 32'hfffffffa},
    '{"multu   ", 32'h00850019, 32'hffffffff, 32'h00000002, 32'hfffffffe,
      32'h00000001, 32'hfffffffe},
    '{"madd    ", 32'h70850000, 32'h00000003, 32'h00000004, 32'h0000000a,
      32'h00000002, 32'h0000000a},
    '{"msub    ", 32'h70850004, 32'hffffffff, 32'h00000005, 32'h0000000f,
      32'h00000002, 32'h0000000f},
    '{"mul     ", 32'h70853002, 32'h00012345, 32'h00000100, 32'h01234500,
      32'h00000002, 32'h0000000f},
    '{"mflo    ", 32'h00003012, 32'h00000000, 32'h00000000, 32'h0000000f,
      32'h00000002, 32'h0000000f},
    '{"mfhiEnd ", 32'h00003010, 32'h00000000, 32'h00000000, 32'h00000002,
      32'h00000002, 32'h0000000f}
};

// ==== tbMipsEx.sv ====
`default_nettype none

module tbMipsEx;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [63:0]      name;
        mipsExPkg::instrT instr;
        mipsExPkg::wordT  rs;
        mipsExPkg::wordT  rt;
        mipsExPkg::wordT  result;
        mipsExPkg::wordT  hi;
        mipsExPkg::wordT  lo;
    } vecT;

    `include "tbMipsExVectors.svh"

    localparam int cycleLimit = numVec * 20;

    logic              clk;
    logic              rstN;
    logic              inValid;
    logic              inReady;
    mipsExPkg::exReqT  inReq;
    logic              outValid;
    logic              outReady;
    mipsExPkg::exRespT outResp;
    logic              illegal;

    int errors = 0;
    int received = 0;
    int cycles = 0;
    int seed = 32'heb301418;
    int sent [$]; // table index of each accepted request

    mipsExTop i_dut (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .inReq(inReq),
        .outValid(outValid), .outReady(outReady), .outResp(outResp), .illegal(illegal)
    );

    always #5 clk = ~clk;

    task automatic checkWord(input logic [63:0] name, input mipsExPkg::wordT expVal,
                             input mipsExPkg::wordT actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("error %s result expected %h actual %h", name, expVal, actVal);
        end
    endtask

    task automatic checkHiLo(input logic [63:0] name, input mipsExPkg::wordT expHi,
                             input mipsExPkg::wordT expLo, input mipsExPkg::wordT actHi,
                             input mipsExPkg::wordT actLo);
        if (actHi !== expHi || actLo !== expLo) begin
            errors++;
            $display("error %s hi:lo expected %h:%h actual %h:%h",
                     name, expHi, expLo, actHi, actLo);
        end
    endtask

    // random back-pressure
    always @(posedge clk) begin
        int r;
        #1;
        r = $random(seed);
        outReady = r[0];
    end

    // handshakes are judged mid-cycle, transfer happens at the next rising edge
    always @(negedge clk) begin
        int k;
        if (rstN && illegal) begin
            errors++;
            $display("illegal flag raised for a supported instruction");
        end
        if (rstN && outValid && outReady) begin
            if (sent.size() == 0) begin
                errors++;
                $display("response arrived with no request outstanding");
            end else begin
                k = sent.pop_front();
                checkWord(vectors[k].name, vectors[k].result, outResp.result);
                checkHiLo(vectors[k].name, vectors[k].hi, vectors[k].lo, outResp.hi, outResp.lo);
                received++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout after %0d cycles with %0d of %0d responses",
                     cycles, received, numVec);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int idx;
        logic taken;
        clk = 1'b0;
        rstN = 1'b0;
        inValid = 1'b0;
        inReq = '0;
        outReady = 1'b0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
        if (outValid !== 1'b0) begin
            errors++;
            $display("outValid is high right after reset");
        end
        idx = 0;
        while (idx < numVec) begin
            inValid = 1'b1;
            inReq = '{instr: vectors[idx].instr, rs: vectors[idx].rs, rt: vectors[idx].rt};
            @(negedge clk);
            taken = inReady;
            if (taken) begin
                sent.push_back(idx);
            end
            @(posedge clk);
            #1;
            if (taken) begin
                idx++;
            end
        end
        inValid = 1'b0;
        wait (received == numVec);
        repeat (4) @(posedge clk); // catch any extra response
        $display("%0d errors in %0d tests, %0d responses", errors, numVec, received);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mipsExPkg.sv
exInput.sv
aluControl.sv
aluCore.sv
hiLoUnit.sv
exOutput.sv
mipsExTop.sv
tbMipsEx.sv
